//--- eg_macros.svh
////////////////////////////////////////
// envelope generator constants
// slot round, level width, ring depth
////////////////////////////////////////
`ifndef EG_MACROS_SVH
`define EG_MACROS_SVH

// one round visits every operator slot once
`define EG_SLOTS       24

`define EG_LVL_W       10     // attenuation, 1 lsb ~ 0.094 dB
`define EG_MAX_LVL     1023   // full attenuation, silence
`define EG_CNT_W       15     // global envelope counter

// level update returns to the ring 3 cycles after phase control
`define EG_RING_STAGES 21

`endif

//--- eg_cfg_pkg.sv
////////////////////////////////////////
// per-slot operator configuration
// as the register file presents it
////////////////////////////////////////
package eg_cfg_pkg;

	// valid while the slot index points at the slot
	typedef struct packed {
		logic       keyon;
		logic [4:0] arate;    // attack
		logic [4:0] d1rate;   // first decay
		logic [4:0] d2rate;   // second decay
		logic [3:0] rrate;    // release
		logic [3:0] d1l;      // sustain level
		logic [1:0] ks;       // key scale
		logic [4:0] keycode;
		logic [6:0] tl;       // total level
	} eg_slot_cfg_t;

endpackage

//--- eg_defs_pkg.sv
////////////////////////////////////////
// envelope pipeline types
// phase encoding and stage records
////////////////////////////////////////
`include "eg_macros.svh"

package eg_defs_pkg;

	typedef enum logic [1:0] {
		ATTACK  = 2'd0,
		DECAY1  = 2'd1,
		DECAY2  = 2'd2,
		RELEASE = 2'd3
	} eg_phase_e;

	// what circulates around the round
	typedef struct packed {
		eg_phase_e             phase;
		logic [`EG_LVL_W-1:0] level;
	} eg_slot_state_t;

	// phase control -> rate step
	typedef struct packed {
		eg_phase_e             phase;
		logic [`EG_LVL_W-1:0] level;
		logic [4:0]            rate;     // base rate of the new phase
		logic                  kon_edge;
		logic [4:0]            keycode;  // carried for key scaling
		logic [1:0]            ks;
	} eg_rate_req_t;

	// rate step -> level update
	typedef struct packed {
		eg_phase_e             phase;
		logic [`EG_LVL_W-1:0] level;
		logic [5:0]            rate;     // scaled, 0..63
		logic                  step;
		logic                  sum_up;
	} eg_step_t;

endpackage

//--- eg_timebase.sv
////////////////////////////////////////
// envelope timebase
// slot index, round start and the
// global envelope counter
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_timebase (
	input  logic                 clk,
	input  logic                 rst,
	output logic [4:0]           slot,
	output logic                 round_start,
	output logic [`EG_CNT_W-1:0] eg_cnt
);

	logic [1:0] div3;   // rounds since last counter tick

	assign round_start = (slot == 5'd0);

	// one slot per clock, never stalls
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= 5'd0;
		end else if (slot == 5'(`EG_SLOTS - 1)) begin
			slot <= 5'd0;
		end else begin
			slot <= slot + 5'd1;
		end
	end

	// counter ticks every third round, wraps freely
	always_ff @(posedge clk) begin
		if (rst) begin
			div3   <= 2'd0;
			eg_cnt <= '0;
		end else if (round_start) begin
			if (div3 == 2'd2) begin
				div3   <= 2'd0;
				eg_cnt <= eg_cnt + 1'b1;
			end else begin
				div3 <= div3 + 2'd1;
			end
		end
	end

endmodule

//--- eg_ring.sv
////////////////////////////////////////
// per-slot delay line
// loads reset_val in every stage
////////////////////////////////////////
`timescale 1ns/1ps

module eg_ring #(
	parameter int               width     = 1,
	parameter int               stages    = 1,
	parameter logic [width-1:0] reset_val = '0
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] sr [stages];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < stages; i++) begin
				sr[i] <= reset_val;
			end
		end else begin
			sr[0] <= din;
			for (int i = 1; i < stages; i++) begin
				sr[i] <= sr[i-1];   // shift one slot per clock
			end
		end
	end

	assign dout = sr[stages-1];

endmodule

//--- eg_phase_ctrl.sv
////////////////////////////////////////
// envelope phase control
// key edges, phase FSM per slot and
// base rate of the next phase
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_phase_ctrl
	import eg_defs_pkg::*, eg_cfg_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  eg_slot_cfg_t   cfg,
	input  eg_slot_state_t prev,        // this slot, one round ago
	input  logic           keyon_last,  // key state one round ago
	output eg_rate_req_t   req
);

	localparam logic [`EG_LVL_W-1:0] MAX_LVL = `EG_MAX_LVL;

	logic       kon_now;
	logic       koff_now;
	logic [4:0] d1_thr;     // sustain threshold on level msbs
	eg_phase_e  nxt_phase;
	logic [4:0] nxt_rate;

	assign kon_now  =  cfg.keyon & ~keyon_last;
	assign koff_now = ~cfg.keyon &  keyon_last;

	// d1l of 15 means the bottom of the range
	assign d1_thr = (cfg.d1l == 4'd15) ? 5'h10 : {1'b0, cfg.d1l};

	//////////////////////////////////////
	// phase transitions
	always_comb begin
		nxt_phase = prev.phase;
		nxt_rate  = cfg.d2rate;
		if (koff_now) begin
			nxt_phase = RELEASE;
			nxt_rate  = {cfg.rrate, 1'b1};   // release rate is 4 bits
		end else if (kon_now) begin
			nxt_phase = ATTACK;
			nxt_rate  = cfg.arate;
		end else begin
			case (prev.phase)
				ATTACK: begin
					if (prev.level == '0) begin   // attack done at the floor
						nxt_phase = DECAY1;
						nxt_rate  = cfg.d1rate;
					end else begin
						nxt_rate = cfg.arate;
					end
				end
				DECAY1: begin
					if (prev.level[`EG_LVL_W-1 -: 5] >= d1_thr) begin
						nxt_phase = DECAY2;
						nxt_rate  = cfg.d2rate;
					end else begin
						nxt_rate = cfg.d1rate;
					end
				end
				DECAY2:  nxt_rate = cfg.d2rate;
				default: nxt_rate = {cfg.rrate, 1'b1};   // release holds
			endcase
		end
	end

	// level passes through untouched, rate step needs key scaling inputs
	always_ff @(posedge clk) begin
		if (rst) begin
			req.phase    <= RELEASE;
			req.level    <= MAX_LVL;
			req.rate     <= 5'd0;
			req.kon_edge <= 1'b0;
			req.keycode  <= 5'd0;
			req.ks       <= 2'd0;
		end else begin
			req.phase    <= nxt_phase;
			req.level    <= prev.level;
			req.rate     <= nxt_rate;
			req.kon_edge <= kon_now;
			req.keycode  <= cfg.keycode;
			req.ks       <= cfg.ks;
		end
	end

endmodule

//--- eg_rate_step.sv
////////////////////////////////////////
// envelope rate step
// key scaling, counter window pick
// and eight-step pattern lookup
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_rate_step
	import eg_defs_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  eg_rate_req_t         req,
	input  logic [`EG_CNT_W-1:0] eg_cnt,
	input  logic                 cnt_lsb_last,  // this slot, one round ago
	output eg_step_t             step,
	output logic                 cnt_lsb
);

	localparam logic [`EG_LVL_W-1:0] MAX_LVL = `EG_MAX_LVL;

	logic [4:0]           ks_add;
	logic [6:0]           pre_rate;
	logic [5:0]           rate;
	logic [3:0]           band;      // top rate bits
	logic                 attack;
	logic [3:0]           cnt_lo;    // low bit of the counter window
	logic [`EG_CNT_W-1:0] cnt_win;
	logic [2:0]           cnt_pick;
	logic [7:0]           pattern;
	logic                 step_now;
	logic                 instant;

	////////////////////////////////////////
	// key scaling, saturating at 63
	assign ks_add   = req.keycode >> (2'd3 - req.ks);
	assign pre_rate = {1'b0, req.rate, 1'b0} + {2'b0, ks_add};
	assign rate     = (req.rate == 5'd0) ? 6'd0 :
	                  pre_rate[6] ? 6'd63 : pre_rate[5:0];
	assign band     = rate[5:2];
	assign attack   = (req.phase == ATTACK);

	// faster bands look at faster counter bits, attack one bit lower
	always_comb begin
		if (attack) begin
			cnt_lo = (band >= 4'd11) ? 4'd0 : 4'd11 - band;
		end else begin
			cnt_lo = (band >= 4'd12) ? 4'd0 : 4'd12 - band;
		end
	end

	assign cnt_win  = eg_cnt >> cnt_lo;
	assign cnt_pick = cnt_win[2:0];
	assign cnt_lsb  = cnt_pick[0];   // goes around the counter ring

	////////////////////////////////////////
	// step patterns, one bit per counter value
	always_comb begin
		if (rate[5:4] == 2'b11) begin
			if (band == 4'hf && attack) begin
				pattern = 8'b11111111;   // fastest attack
			end else begin
				case (rate[1:0])
					2'd0:    pattern = 8'b00000000;
					2'd1:    pattern = 8'b10001000;
					2'd2:    pattern = 8'b10101010;
					default: pattern = 8'b11101110;
				endcase
			end
		end else if (band == 4'd0 && !attack) begin
			pattern = 8'b11111110;   // slowest decay
		end else begin
			case (rate[1:0])
				2'd0:    pattern = 8'b10101010;
				2'd1:    pattern = 8'b11101010;
				2'd2:    pattern = 8'b11101110;
				default: pattern = 8'b11111110;
			endcase
		end
	end

	assign step_now = (rate[5:1] == 5'd0) ? 1'b0 : pattern[cnt_pick];

	// key-on at rate 62/63 jumps to the floor without waiting for the counter
	assign instant = req.kon_edge & (rate[5:1] == 5'd31);

	always_ff @(posedge clk) begin
		if (rst) begin
			step.phase  <= RELEASE;
			step.level  <= MAX_LVL;
			step.rate   <= 6'd0;
			step.step   <= 1'b0;
			step.sum_up <= 1'b0;
		end else begin
			step.phase  <= req.phase;
			step.level  <= req.level;
			step.rate   <= rate;
			step.step   <= step_now | instant;
			step.sum_up <= (cnt_lsb != cnt_lsb_last) | instant;
		end
	end

endmodule

//--- eg_level_update.sv
////////////////////////////////////////
// envelope level update
// attack/decay arithmetic, saturation,
// total level and phase reset pulse
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_level_update
	import eg_defs_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  eg_step_t             step,
	input  logic [7:0]           tl,        // {key-on edge, total level}
	output eg_slot_state_t       next,
	output logic [`EG_LVL_W-1:0] eg_level,
	output logic                 pg_rst
);

	localparam logic [`EG_LVL_W-1:0] MAX_LVL = `EG_MAX_LVL;

	logic [3:0]            band;
	logic [`EG_LVL_W-1:0]  ar_frac;   // fraction of level plus one
	logic [`EG_LVL_W-1:0]  ar_dec;
	logic [`EG_LVL_W-1:0]  ar_lvl;
	logic [3:0]            dr_inc;    // 1, 2, 4 or 8
	logic [`EG_LVL_W:0]    dr_sum;
	logic [`EG_LVL_W-1:0]  new_lvl;
	logic                  sat_q;     // level just hit full attenuation
	logic [`EG_LVL_W:0]    att_sum;

	assign band = step.rate[5:2];

	// attack moves toward 0 by a fraction of the current level
	always_comb begin
		case (band)
			4'd13:        ar_frac = {3'b0, step.level[9:3]} + 10'd1;
			4'd14, 4'd15: ar_frac = {2'b0, step.level[9:2]} + 10'd1;
			default:      ar_frac = {4'b0, step.level[9:4]} + 10'd1;
		endcase
		if (band >= 4'd12) begin
			ar_dec = step.step ? ar_frac << 1 : ar_frac;
		end else begin
			ar_dec = step.step ? ar_frac : 10'd0;
		end
		ar_lvl = (ar_dec < step.level) ? step.level - ar_dec : 10'd0;
	end

	// decay and release climb linearly
	always_comb begin
		case (band)
			4'd12:   dr_inc = step.step ? 4'd2 : 4'd1;
			4'd13:   dr_inc = step.step ? 4'd4 : 4'd2;
			4'd14:   dr_inc = step.step ? 4'd8 : 4'd4;
			4'd15:   dr_inc = 4'd8;
			default: dr_inc = {3'b0, step.step};
		endcase
		dr_sum = {1'b0, step.level} + {7'b0, dr_inc};
	end

	always_comb begin
		new_lvl = step.level;
		if (step.sum_up) begin
			if (step.phase == ATTACK) begin
				if (step.level != '0) begin
					new_lvl = (step.rate[5:1] == 5'd31) ? '0 : ar_lvl;
				end
			end else begin
				new_lvl = dr_sum[`EG_LVL_W] ? MAX_LVL : dr_sum[`EG_LVL_W-1:0];
			end
		end
	end

	// back into the ring
	always_ff @(posedge clk) begin
		if (rst) begin
			next.phase <= RELEASE;
			next.level <= MAX_LVL;
			sat_q      <= 1'b0;
		end else begin
			next.phase <= step.phase;
			next.level <= new_lvl;
			sat_q      <= (new_lvl == MAX_LVL) && (step.level != MAX_LVL);
		end
	end

	////////////////////////////////////////
	// output attenuation, tl in steps of 8
	assign att_sum = {1'b0, next.level} + {1'b0, tl[6:0], 3'b0};

	always_ff @(posedge clk) begin
		if (rst) begin
			eg_level <= MAX_LVL;
			pg_rst   <= 1'b0;
		end else begin
			eg_level <= att_sum[`EG_LVL_W] ? MAX_LVL : att_sum[`EG_LVL_W-1:0];
			pg_rst   <= tl[7] | sat_q;
		end
	end

endmodule

//--- fm_eg.sv
////////////////////////////////////////
// FM envelope generator, 24 slots
// time-multiplexed, one slot per clock
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module fm_eg
	import eg_defs_pkg::*, eg_cfg_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  eg_slot_cfg_t         cfg,       // for the slot under the index
	output logic [4:0]           slot,
	output logic [`EG_LVL_W-1:0] eg_level,  // slot - 4 mod 24
	output logic                 pg_rst
);

	localparam eg_slot_state_t IDLE_STATE = '{phase: RELEASE, level: `EG_MAX_LVL};
	localparam int TL_DELAY = 3;   // cfg cycle to level update

	logic [`EG_CNT_W-1:0] eg_cnt;
	eg_slot_state_t       prev;
	eg_slot_state_t       next;
	eg_rate_req_t         req;
	eg_step_t             step;
	logic                 keyon_last;
	logic                 cnt_lsb;
	logic                 cnt_lsb_last;
	logic                 kon_edge;
	logic [7:0]           tl_al;      // {key-on edge, tl} aligned

	// same edge phase control sees, kept for the pg_rst stage
	assign kon_edge = cfg.keyon & ~keyon_last;

	eg_timebase u_timebase (
		.clk(clk), .rst(rst), .slot(slot), .round_start(), .eg_cnt(eg_cnt)
	);

	eg_phase_ctrl u_phase (
		.clk(clk), .rst(rst), .cfg(cfg), .prev(prev),
		.keyon_last(keyon_last), .req(req)
	);

	eg_rate_step u_rate (
		.clk(clk), .rst(rst), .req(req), .eg_cnt(eg_cnt),
		.cnt_lsb_last(cnt_lsb_last), .step(step), .cnt_lsb(cnt_lsb)
	);

	eg_level_update u_level (
		.clk(clk), .rst(rst), .step(step), .tl(tl_al),
		.next(next), .eg_level(eg_level), .pg_rst(pg_rst)
	);

	//////////////////////////////////////
	// slot rings
	eg_ring #(.width($bits(eg_slot_state_t)), .stages(`EG_RING_STAGES),
		.reset_val(IDLE_STATE)) u_state_ring (
		.clk(clk), .rst(rst), .din(next), .dout(prev)
	);

	eg_ring #(.width(1), .stages(`EG_SLOTS)) u_key_ring (
		.clk(clk), .rst(rst), .din(cfg.keyon), .dout(keyon_last)
	);

	eg_ring #(.width(1), .stages(`EG_SLOTS)) u_cnt_ring (
		.clk(clk), .rst(rst), .din(cnt_lsb), .dout(cnt_lsb_last)
	);

	eg_ring #(.width(8), .stages(TL_DELAY)) u_tl_ring (
		.clk(clk), .rst(rst), .din({kon_edge, cfg.tl}), .dout(tl_al)
	);

endmodule

//--- fm_eg_props.sv
////////////////////////////////////////
// envelope output checks
// per-slot shadows of cfg, bound to fm_eg
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module fm_eg_props
	import eg_cfg_pkg::*;
(
	input logic                 clk,
	input logic                 rst,
	input eg_slot_cfg_t         cfg,
	input logic [4:0]           slot,
	input logic [`EG_LVL_W-1:0] eg_level,
	input logic                 pg_rst
);

	eg_slot_cfg_t         cfg_pipe [4];            // cfg as it was 4 cycles ago
	logic [4:0]           slot_pipe [4];
	logic [4:0]           slot_exp;                // slot index the round should be at
	int                   cyc;                     // cycles since reset
	int                   fail_cnt;                // read by the testbench
	logic                 key_last [`EG_SLOTS];
	logic [6:0]           tl_last [`EG_SLOTS];
	logic [`EG_LVL_W-1:0] lvl_last [`EG_SLOTS];
	logic                 floor_seen [`EG_SLOTS];  // attack reached level 0
	logic                 ever_on [`EG_SLOTS];
	int                   rel_rounds [`EG_SLOTS];
	eg_slot_cfg_t         oc;                      // cfg of the slot now at the output
	logic [4:0]           os;
	logic                 out_valid;
	logic                 kon;
	logic                 frozen;
	logic                 decay_chk;
	logic                 rel_chk;
	logic [`EG_LVL_W:0]   tl_att;                  // tl*8, unclamped
	logic [`EG_LVL_W-1:0] inst_exp;
	logic [`EG_LVL_W:0]   lvl_top;                 // last level plus one big step

	assign oc        = cfg_pipe[3];
	assign os        = slot_pipe[3];
	assign out_valid = (cyc >= 4);
	assign kon       = out_valid && oc.keyon && !key_last[os];
	assign frozen    = out_valid && oc.keyon && oc.arate == 0 && oc.d1rate == 0 &&
	                   oc.d2rate == 0 && oc.rrate == 0;
	assign decay_chk = out_valid && floor_seen[os] && oc.keyon && key_last[os] &&
	                   oc.tl == tl_last[os];
	assign rel_chk   = out_valid && ever_on[os] && !oc.keyon && oc.rrate == 4'd15 &&
	                   oc.tl == tl_last[os];
	assign tl_att    = {4'b0, oc.tl} * 11'd8;
	// min(tl*8, full attenuation)
	assign inst_exp  = (tl_att > 11'(`EG_MAX_LVL)) ? 10'(`EG_MAX_LVL) :
	                   tl_att[`EG_LVL_W-1:0];
	assign lvl_top   = {1'b0, lvl_last[os]} + 11'd8;

	//////////////////////////////////////
	// shadow state, one update per output cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			cyc      <= 0;
			slot_exp <= 5'd0;
			for (int i = 0; i < 4; i++) begin
				cfg_pipe[i]  <= '0;
				slot_pipe[i] <= 5'd0;
			end
			for (int s = 0; s < `EG_SLOTS; s++) begin
				key_last[s]   <= 1'b0;
				tl_last[s]    <= 7'd0;
				lvl_last[s]   <= `EG_MAX_LVL;
				floor_seen[s] <= 1'b0;
				ever_on[s]    <= 1'b0;
				rel_rounds[s] <= 0;
			end
		end else begin
			if (cyc < 1000) cyc <= cyc + 1;   // saturate, only small values matter
			slot_exp     <= 5'((slot_exp + 1) % `EG_SLOTS);   // one slot per clock
			cfg_pipe[0]  <= cfg;
			slot_pipe[0] <= slot;
			for (int i = 1; i < 4; i++) begin
				cfg_pipe[i]  <= cfg_pipe[i-1];
				slot_pipe[i] <= slot_pipe[i-1];
			end
			if (out_valid) begin
				key_last[os] <= oc.keyon;
				tl_last[os]  <= oc.tl;
				lvl_last[os] <= eg_level;
				if (!oc.keyon) floor_seen[os] <= 1'b0;
				else if (eg_level == inst_exp) floor_seen[os] <= 1'b1;
				if (oc.keyon) ever_on[os] <= 1'b1;
				if (oc.keyon) begin
					rel_rounds[os] <= 0;
				end else if (rel_chk && eg_level != `EG_MAX_LVL) begin
					rel_rounds[os] <= rel_rounds[os] + 1;
				end
			end
		end
	end

	//////////////////////////////////////
	// assertions
	a_slot: assert property (@(posedge clk) disable iff (rst) slot == slot_exp)
		else begin
			fail_cnt++;
			$error("ERR slot_count exp %0d got %0d", slot_exp, slot);
		end

	a_reset: assert property (@(posedge clk) disable iff (rst)
		cyc < 28 |-> (eg_level == `EG_MAX_LVL && !pg_rst))
		else begin
			fail_cnt++;
			$error("ERR reset exp %0d got %0d pg_rst %0b", `EG_MAX_LVL, eg_level, pg_rst);
		end

	a_kon_pulse: assert property (@(posedge clk) disable iff (rst) kon |-> pg_rst)
		else begin
			fail_cnt++;
			$error("ERR kon_pulse slot %0d exp 1 got %0b", os, pg_rst);
		end

	a_instant: assert property (@(posedge clk) disable iff (rst)
		(kon && oc.arate == 5'd31) |-> eg_level == inst_exp)
		else begin
			fail_cnt++;
			$error("ERR instant_attack slot %0d exp %0d got %0d", os, inst_exp, eg_level);
		end

	a_frozen: assert property (@(posedge clk) disable iff (rst)
		frozen |-> eg_level == `EG_MAX_LVL)
		else begin
			fail_cnt++;
			$error("ERR frozen_attack slot %0d exp %0d got %0d", os, `EG_MAX_LVL, eg_level);
		end

	// at most one step of 8 per round
	a_decay: assert property (@(posedge clk) disable iff (rst)
		decay_chk |-> (eg_level >= lvl_last[os] && {1'b0, eg_level} <= lvl_top))
		else begin
			fail_cnt++;
			$error("ERR decay_monotonic slot %0d exp %0d..%0d got %0d", os, lvl_last[os],
				lvl_top, eg_level);
		end

	a_release: assert property (@(posedge clk) disable iff (rst)
		rel_chk |-> (eg_level >= lvl_last[os] && rel_rounds[os] < 1500))
		else begin
			fail_cnt++;
			$error("ERR release slot %0d exp >= %0d got %0d after %0d rounds", os,
				lvl_last[os], eg_level, rel_rounds[os]);
		end

	// a sum past full attenuation that wrapped would land below tl*8
	a_range: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (!$isunknown(eg_level) && eg_level >= inst_exp))
		else begin
			fail_cnt++;
			$error("ERR range slot %0d exp >= %0d got %0d", os, inst_exp, eg_level);
		end

endmodule

bind fm_eg fm_eg_props props0 (
	.clk(clk), .rst(rst), .cfg(cfg), .slot(slot), .eg_level(eg_level), .pg_rst(pg_rst)
);

//--- fm_eg_tb.sv
////////////////////////////////////////
// testbench for the FM envelope generator
// per-slot scenarios, watchdog, verdict
////////////////////////////////////////
`timescale 1ns/1ps
`include "eg_macros.svh"

module fm_eg_tb
	import eg_cfg_pkg::*;
;

	localparam int CLK_NS   = 100;
	localparam int RUN_RNDS = 1600;                       // release needs ~400 rounds
	localparam int WD_NS    = 2000 * `EG_SLOTS * CLK_NS;  // watchdog, 2000 rounds
	localparam int KON_RND  = 2;                          // keys stay off before this
	localparam int KOFF_RND = 20;                         // release slots let go here

	logic                 clk;
	logic                 rst;
	eg_slot_cfg_t         cfg;
	logic [4:0]           slot;
	logic [`EG_LVL_W-1:0] eg_level;
	logic                 pg_rst;

	eg_slot_cfg_t base [`EG_SLOTS];   // fixed part of each slot's scenario
	int           seed;
	int           rnd;                // round counter, 0 = first round after reset
	logic [4:0]   nxt;

	fm_eg dut0 (
		.clk(clk), .rst(rst), .cfg(cfg), .slot(slot), .eg_level(eg_level), .pg_rst(pg_rst)
	);

	// scenario by slot index
	//   0 mod 4  instant attack then decay
	//   1 mod 4  keyed on with all rates 0
	//   2 mod 4  instant attack, key off later, fast release
	//   3 mod 4  slower attack then decay
	function automatic eg_slot_cfg_t slot_cfg(input int idx, input int round);
		eg_slot_cfg_t c;
		c       = base[idx];
		c.keyon = (round >= KON_RND);
		if (idx % 4 == 2 && round >= KOFF_RND) c.keyon = 1'b0;
		return c;
	endfunction

	//////////////////////////////////////
	// clock and scenario table
	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		seed = 32'h76a0524e;
		for (int s = 0; s < `EG_SLOTS; s++) begin
			base[s]         = '0;
			base[s].tl      = 7'($random(seed));
			base[s].keycode = 5'($random(seed));
			base[s].ks      = 2'($random(seed));
			base[s].d1l     = 4'($random(seed));
			base[s].d1rate  = 5'($random(seed));
			base[s].d2rate  = 5'($random(seed));
			base[s].rrate   = 4'($random(seed));
			case (s % 4)
				0: base[s].arate = 5'd31;
				1: begin
					base[s].arate  = 5'd0;
					base[s].d1rate = 5'd0;
					base[s].d2rate = 5'd0;
					base[s].rrate  = 4'd0;
				end
				2: begin
					base[s].arate = 5'd31;
					base[s].rrate = 4'd15;
				end
				default: base[s].arate = 5'd20 + 5'($unsigned($random(seed)) % 10);
			endcase
		end
	end

	//////////////////////////////////////
	// stimulus, cfg for the slot of the next cycle
	initial begin
		rst = 1'b1;
		cfg = '0;
		rnd = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

	always @(posedge clk) begin
		nxt = rst ? 5'd0 : (slot == 5'(`EG_SLOTS - 1)) ? 5'd0 : slot + 5'd1;
		if (!rst && slot == 5'(`EG_SLOTS - 1)) begin
			rnd <= rnd + 1;
			cfg <= slot_cfg(nxt, rnd + 1);
		end else begin
			cfg <= slot_cfg(nxt, rnd);
		end
	end

	//////////////////////////////////////
	// verdict
	always @(posedge clk) begin
		if (dut0.props0.fail_cnt != 0) begin
			$display("** FAIL **");
			$fatal(1, "assertion failed in the bound checker");
		end
	end

	initial begin
		#(WD_NS);
		$display("** FAIL **");
		$fatal(1, "watchdog expired before the run completed");
	end

	initial begin
		@(negedge rst);
		while (rnd < RUN_RNDS) @(posedge clk);
		repeat (2) @(posedge clk);   // let the last checks settle
		if (dut0.props0.fail_cnt != 0) begin
			$display("** FAIL **");
			$fatal(1, "assertion failures seen");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- fm_eg.f
+incdir+.
eg_cfg_pkg.sv
eg_defs_pkg.sv
eg_timebase.sv
eg_ring.sv
eg_phase_ctrl.sv
eg_rate_step.sv
eg_level_update.sv
fm_eg.sv
fm_eg_props.sv
fm_eg_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the envelope generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fm_eg_tb -f fm_eg.f \
	-o fm_eg_sim > build.log 2>&1 \
	&& ./obj_dir/fm_eg_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
